// ==== Bender.yml ====
package:
  name: data_mem

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dm_types_pkg.sv
      - hdl/dm_inst_pkg.sv
      - hdl/sdp_bram.sv
      - hdl/region_writer.sv
      - hdl/write_arbiter.sv
      - hdl/operand_reader.sv
      - hdl/data_mem.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/dm_tb.sv

// ==== all.f ====
+incdir+hdl
hdl/dm_types_pkg.sv
hdl/dm_inst_pkg.sv
hdl/sdp_bram.sv
hdl/region_writer.sv
hdl/write_arbiter.sv
hdl/operand_reader.sv
hdl/data_mem.sv
verif/dm_tb.sv

// ==== hdl/data_mem.sv ====
`include "dm_defs.svh"

module data_mem (
    input  logic                   clk,
    input  logic                   rst,
    // Region bursts
    input  logic                   load_valid,
    output logic                   load_ready,
    input  dm_types_pkg::wr_beat_t load_beat,
    input  logic                   shift_valid,
    output logic                   shift_ready,
    input  dm_types_pkg::wr_beat_t shift_beat,
    input  logic                   tx_valid,
    output logic                   tx_ready,
    input  dm_types_pkg::wr_beat_t tx_beat,
    // ALU results
    input  logic                   wb_valid,
    output logic                   wb_ready,
    input  dm_types_pkg::cplx_t    wb_data,
    // Instructions in, operand pairs out
    input  logic                   inst_valid,
    output logic                   inst_ready,
    input  dm_inst_pkg::dm_inst_t  inst,
    output logic                   op_valid,
    input  logic                   op_ready,
    output dm_types_pkg::operand_t op
);

    import dm_types_pkg::*;
    import dm_inst_pkg::*;

    logic    load_req_valid, load_req_ready;
    logic    shift_req_valid, shift_req_ready;
    logic    tx_req_valid, tx_req_ready;
    addr_t   load_req_addr, shift_req_addr, tx_req_addr;
    cplx_t   load_req_data, shift_req_data, tx_req_data;
    addr_t   wb_dest;
    logic    wb_pending, wb_pop;
    ram_wr_t ram_wr;
    addr_t   raddr_a, raddr_b;
    logic    rd_en, rd_regce;
    cplx_t   dout_a, dout_b;

    //////////////////////////////////////////////////////////////////////
    // Region writers

    region_writer #(.BASE(`DM_LOAD_BASE)) u_load_wr (
        .clk, .rst,
        .beat_valid(load_valid), .beat_ready(load_ready), .beat(load_beat),
        .req_valid(load_req_valid), .req_ready(load_req_ready),
        .req_addr(load_req_addr), .req_data(load_req_data)
    );

    region_writer #(.BASE(`DM_SHIFT_BASE)) u_shift_wr (
        .clk, .rst,
        .beat_valid(shift_valid), .beat_ready(shift_ready), .beat(shift_beat),
        .req_valid(shift_req_valid), .req_ready(shift_req_ready),
        .req_addr(shift_req_addr), .req_data(shift_req_data)
    );

    region_writer #(.BASE(`DM_TX_BASE)) u_tx_wr (
        .clk, .rst,
        .beat_valid(tx_valid), .beat_ready(tx_ready), .beat(tx_beat),
        .req_valid(tx_req_valid), .req_ready(tx_req_ready),
        .req_addr(tx_req_addr), .req_data(tx_req_data)
    );

    //////////////////////////////////////////////////////////////////////
    // Write port sharing and read side

    write_arbiter u_arb (
        .clk, .rst,
        .load_valid(load_req_valid), .load_ready(load_req_ready),
        .load_addr(load_req_addr), .load_data(load_req_data),
        .shift_valid(shift_req_valid), .shift_ready(shift_req_ready),
        .shift_addr(shift_req_addr), .shift_data(shift_req_data),
        .tx_valid(tx_req_valid), .tx_ready(tx_req_ready),
        .tx_addr(tx_req_addr), .tx_data(tx_req_data),
        .wb_valid, .wb_ready, .wb_data, .wb_dest, .wb_pending, .wb_pop,
        .ram_wr
    );

    operand_reader u_reader (
        .clk, .rst,
        .inst_valid, .inst_ready, .inst,
        .op_valid, .op_ready, .op,
        .raddr_a, .raddr_b, .rd_en, .rd_regce, .dout_a, .dout_b,
        .wb_pop, .wb_dest, .wb_pending
    );

    // Mirrored RAMs, same writes, one source each
    sdp_bram #(.DEPTH(`DM_DEPTH)) u_bram_a (
        .clk, .rst,
        .we(ram_wr.we), .waddr(ram_wr.addr), .wdata(ram_wr.data),
        .raddr(raddr_a), .en(rd_en), .regce(rd_regce), .dout(dout_a)
    );

    sdp_bram #(.DEPTH(`DM_DEPTH)) u_bram_b (
        .clk, .rst,
        .we(ram_wr.we), .waddr(ram_wr.addr), .wdata(ram_wr.data),
        .raddr(raddr_b), .en(rd_en), .regce(rd_regce), .dout(dout_b)
    );

endmodule

// ==== hdl/dm_defs.svh ====
`ifndef DM_DEFS_SVH
`define DM_DEFS_SVH

// Word and memory geometry
`define DM_DATA_WIDTH 16   // One real or imaginary part
`define DM_ADDR_WIDTH 8
`define DM_DEPTH      256

// Region bases for the burst writers
`define DM_LOAD_BASE  0    // Sample load
`define DM_SHIFT_BASE 32   // Shifted samples
`define DM_TX_BASE    160  // Alpha history

// Destinations waiting for their ALU result
`define DM_WB_QDEPTH  4

`endif

// ==== hdl/dm_inst_pkg.sv ====
`include "dm_defs.svh"

package dm_inst_pkg;

    typedef logic [`DM_ADDR_WIDTH-1:0] addr_t;

    // Field order follows the instruction word, src_b on top
    typedef struct packed {
        addr_t src_b;  // Second operand
        addr_t src_a;  // First operand
        addr_t dest;   // Write-back target
    } dm_inst_t;

endpackage

// ==== hdl/dm_types_pkg.sv ====
`include "dm_defs.svh"

package dm_types_pkg;

    // Complex sample, real part in the upper half
    typedef struct packed {
        logic [`DM_DATA_WIDTH-1:0] re;
        logic [`DM_DATA_WIDTH-1:0] im;
    } cplx_t;

    // One beat of a region burst
    typedef struct packed {
        cplx_t data;
        logic  last;  // End of burst, address goes back to base
    } wr_beat_t;

    // Shared write port of both RAMs
    typedef struct packed {
        logic                      we;
        logic [`DM_ADDR_WIDTH-1:0] addr;
        cplx_t                     data;
    } ram_wr_t;

    // Both sources of one instruction
    typedef struct packed {
        cplx_t a;
        cplx_t b;
    } operand_t;

endpackage

// ==== hdl/operand_reader.sv ====
`include "dm_defs.svh"

module operand_reader (
    input  logic                   clk,
    input  logic                   rst,
    // Instruction stream
    input  logic                   inst_valid,
    output logic                   inst_ready,
    input  dm_inst_pkg::dm_inst_t  inst,
    // Operand stream
    output logic                   op_valid,
    input  logic                   op_ready,
    output dm_types_pkg::operand_t op,
    // RAM read side, both RAMs share the enables
    output dm_inst_pkg::addr_t     raddr_a,
    output dm_inst_pkg::addr_t     raddr_b,
    output logic                   rd_en,
    output logic                   rd_regce,
    input  dm_types_pkg::cplx_t    dout_a,
    input  dm_types_pkg::cplx_t    dout_b,
    // Destination queue toward the arbiter
    input  logic                   wb_pop,
    output dm_inst_pkg::addr_t     wb_dest,
    output logic                   wb_pending
);

    import dm_types_pkg::*;
    import dm_inst_pkg::*;

    localparam int QD = `DM_WB_QDEPTH;
    localparam int PW = $clog2(QD);

    logic          advance;    // Whole pipe moves together
    logic          inst_fire;
    logic          v_addr;     // Stage 1, address register
    logic          v_latch;    // Stage 2, RAM read latch
    logic          q_full;
    addr_t         dest_q [QD];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;

    function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
        return (p == PW'(QD - 1)) ? '0 : p + 1'b1;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Read pipeline, addr reg -> RAM latch -> RAM output reg

    assign advance    = !op_valid || op_ready;  // Output stage empty or draining
    assign q_full     = (count == (PW + 1)'(QD));
    assign inst_ready = advance && !q_full;
    assign inst_fire  = inst_valid && inst_ready;

    assign rd_en    = advance;
    assign rd_regce = advance;
    assign op       = operand_t'{a: dout_a, b: dout_b};

    always_ff @(posedge clk) begin
        if (advance) begin
            raddr_a <= inst.src_a;
            raddr_b <= inst.src_b;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            v_addr   <= 1'b0;
            v_latch  <= 1'b0;
            op_valid <= 1'b0;
        end else if (advance) begin
            v_addr   <= inst_fire;
            v_latch  <= v_addr;
            op_valid <= v_latch;  // Stage 3 lives in the RAM output reg
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Destination queue, results come back in instruction order

    assign wb_dest    = dest_q[rd_ptr];
    assign wb_pending = (count != '0);

    always_ff @(posedge clk) begin
        if (inst_fire) begin
            dest_q[wr_ptr] <= inst.dest;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (inst_fire) wr_ptr <= ptr_next(wr_ptr);
            if (wb_pop) rd_ptr <= ptr_next(rd_ptr);  // Only when pending
            case ({inst_fire, wb_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Push and pop cancel
            endcase
        end
    end

endmodule

// ==== hdl/region_writer.sv ====
module region_writer #(
    parameter int unsigned BASE = 0
) (
    input  logic                   clk,
    input  logic                   rst,
    // Burst from the source
    input  logic                   beat_valid,
    output logic                   beat_ready,
    input  dm_types_pkg::wr_beat_t beat,
    // Addressed request toward the arbiter
    output logic                   req_valid,
    input  logic                   req_ready,
    output dm_inst_pkg::addr_t     req_addr,
    output dm_types_pkg::cplx_t    req_data
);

    import dm_types_pkg::*;
    import dm_inst_pkg::*;

    localparam addr_t BASE_ADDR = addr_t'(BASE);

    addr_t addr_q;  // Next address in the region
    logic  fire;

    //////////////////////////////////////////////////////////////////////
    // Request side, combinational

    assign req_valid  = beat_valid;
    assign beat_ready = req_ready;  // Arbiter decides for us
    assign req_addr   = addr_q;
    assign req_data   = cplx_t'(beat.data);

    assign fire = beat_valid && req_ready;

    //////////////////////////////////////////////////////////////////////
    // Address counter

    // Wraps to the base after the last beat, so every burst starts there
    always_ff @(posedge clk) begin
        if (rst) begin
            addr_q <= BASE_ADDR;
        end else if (fire) begin
            if (beat.last) begin
                addr_q <= BASE_ADDR;
            end else begin
                addr_q <= addr_q + addr_t'(1);
            end
        end
    end

endmodule

// ==== hdl/sdp_bram.sv ====
`include "dm_defs.svh"

module sdp_bram #(
    parameter int DEPTH = `DM_DEPTH,
    parameter int WIDTH = 2 * `DM_DATA_WIDTH
) (
    input  logic                     clk,
    input  logic                     rst,
    // Write port
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [WIDTH-1:0]         wdata,
    // Read port
    input  logic [$clog2(DEPTH)-1:0] raddr,
    input  logic                     en,     // Read latch enable
    input  logic                     regce,  // Output register enable
    output logic [WIDTH-1:0]         dout
);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [WIDTH-1:0] rd_latch;

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read before write on a shared address
    always_ff @(posedge clk) begin
        if (en) begin
            rd_latch <= mem[raddr];
        end
    end

    // Output stage, only this one sees reset
    always_ff @(posedge clk) begin
        if (rst) begin
            dout <= '0;
        end else if (regce) begin
            dout <= rd_latch;
        end
    end

endmodule

// ==== hdl/write_arbiter.sv ====
module write_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    // Load region, highest priority
    input  logic                  load_valid,
    output logic                  load_ready,
    input  dm_inst_pkg::addr_t    load_addr,
    input  dm_types_pkg::cplx_t   load_data,
    // Shift region
    input  logic                  shift_valid,
    output logic                  shift_ready,
    input  dm_inst_pkg::addr_t    shift_addr,
    input  dm_types_pkg::cplx_t   shift_data,
    // Alpha history region
    input  logic                  tx_valid,
    output logic                  tx_ready,
    input  dm_inst_pkg::addr_t    tx_addr,
    input  dm_types_pkg::cplx_t   tx_data,
    // ALU write-back, lowest priority
    input  logic                  wb_valid,
    output logic                  wb_ready,
    input  dm_types_pkg::cplx_t   wb_data,
    input  dm_inst_pkg::addr_t    wb_dest,     // Head of destination queue
    input  logic                  wb_pending,  // Queue not empty
    output logic                  wb_pop,
    // Registered write into both RAMs
    output dm_types_pkg::ram_wr_t ram_wr
);

    import dm_types_pkg::*;
    import dm_inst_pkg::*;

    addr_t sel_addr;
    cplx_t sel_data;
    logic  sel_we;

    //////////////////////////////////////////////////////////////////////
    // Fixed priority, load > shift > tx > write-back

    assign load_ready  = 1'b1;  // Nobody above it
    assign shift_ready = !load_valid;
    assign tx_ready    = !load_valid && !shift_valid;
    assign wb_ready    = !load_valid && !shift_valid && !tx_valid && wb_pending;

    assign wb_pop = wb_valid && wb_ready;  // Same edge as the write-back transfer

    always_comb begin
        sel_we = 1'b1;
        if (load_valid) begin
            sel_addr = load_addr;
            sel_data = load_data;
        end else if (shift_valid) begin
            sel_addr = shift_addr;
            sel_data = shift_data;
        end else if (tx_valid) begin
            sel_addr = tx_addr;
            sel_data = tx_data;
        end else begin
            sel_addr = wb_dest;  // Destination named by the instruction
            sel_data = wb_data;
            sel_we   = wb_pop;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // One write per cycle, stored by the RAM on the next edge

    always_ff @(posedge clk) begin
        ram_wr.addr <= sel_addr;
        ram_wr.data <= sel_data;
        if (rst) begin
            ram_wr.we <= 1'b0;
        end else begin
            ram_wr.we <= sel_we;
        end
    end

endmodule

// ==== verif/dm_tb.sv ====
`include "dm_defs.svh"

module dm_tb;

    import dm_types_pkg::*;
    import dm_inst_pkg::*;

    localparam int TMO = 2000;  // Cycles per wait loop

    logic     clk, rst;
    logic     rv [3];           // Region valids: load, shift, tx
    logic     rr [3];
    wr_beat_t rb [3];
    logic     wb_valid, wb_ready;
    cplx_t    wb_data;
    logic     inst_valid, inst_ready;
    dm_inst_t inst;
    logic     op_valid, op_ready;
    operand_t op;

    cplx_t    model [`DM_DEPTH];  // Reference memory
    addr_t    ptr [3];            // Expected region counters
    operand_t exp_q [$];          // Operands still owed by the DUT
    addr_t    dq [$];             // Destinations waiting for write-back
    bit       bp_on;
    int       checks, errors;

    data_mem u_data_mem (
        .clk, .rst,
        .load_valid(rv[0]), .load_ready(rr[0]), .load_beat(rb[0]),
        .shift_valid(rv[1]), .shift_ready(rr[1]), .shift_beat(rb[1]),
        .tx_valid(rv[2]), .tx_ready(rr[2]), .tx_beat(rb[2]),
        .wb_valid, .wb_ready, .wb_data,
        .inst_valid, .inst_ready, .inst,
        .op_valid, .op_ready, .op
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic addr_t base_of(input int s);
        case (s)
            0:       return addr_t'(`DM_LOAD_BASE);
            1:       return addr_t'(`DM_SHIFT_BASE);
            default: return addr_t'(`DM_TX_BASE);
        endcase
    endfunction

    function automatic string ready_name(input int s);
        case (s)
            0:       return "load_ready";
            1:       return "shift_ready";
            default: return "tx_ready";
        endcase
    endfunction

    // Both sources straight from the model
    function automatic operand_t ref_operand(input dm_inst_t x);
        return '{a: model[x.src_a], b: model[x.src_b]};
    endfunction

    function automatic cplx_t fill_word(input addr_t a);
        return '{re: {8'ha5, a}, im: {~a, a ^ 8'h3c}};
    endfunction

    task automatic timeout_exit(input string what);
        $display("Timeout: %s", what);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic finish_test(input string name, input int err0);
        $display("test %-28s %s", name, (errors == err0) ? "ok" : "FAILED");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stream drivers, each returns on the edge of its last transfer

    task automatic send_burst(input int s, input int len, input bit fill);
        int n;
        for (int i = 0; i < len; i++) begin
            rv[s] <= 1'b1;
            rb[s] <= '{data: fill ? fill_word(addr_t'(i)) : cplx_t'($urandom),
                       last: (i == len - 1)};
            n = 0;
            do begin
                @(posedge clk);
                n++;
            end while (!rr[s] && n < TMO);  // Ready sampled before the edge
            assert (rr[s]) else timeout_exit($sformatf("stream %0d beat %0d stuck", s, i));
        end
        rv[s] <= 1'b0;
    endtask

    task automatic send_inst(input dm_inst_t x);
        int n;
        inst_valid <= 1'b1;
        inst       <= x;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!inst_ready && n < TMO);
        assert (inst_ready) else timeout_exit("instruction never accepted");
    endtask

    // Checked on falling edges so the monitor has run
    task automatic drain();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while ((exp_q.size() != 0 || dq.size() != 0) && n < TMO);
        assert (exp_q.size() == 0 && dq.size() == 0)
            else timeout_exit("operands or write-backs still outstanding");
        @(posedge clk);
    endtask

    task automatic read_span(input int base, input int len);
        for (int i = 0; i < len; i++) begin
            send_inst(dm_inst_t'{src_b: addr_t'(base + len - 1 - i), src_a: addr_t'(base + i),
                                 dest: addr_t'(240 + i % 16)});
        end
        inst_valid <= 1'b0;
        drain();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Background sinks and sources

    initial begin
        wb_valid = 1'b0;
        wb_data  = '0;
        op_ready = 1'b1;
        forever begin
            @(posedge clk);
            if (!rst) begin
                wb_valid <= 1'b1;  // ALU always has a result ready
                if (wb_valid && wb_ready) wb_data <= cplx_t'($urandom);
                op_ready <= bp_on ? ($urandom % 3 != 0) : 1'b1;
            end
        end
    end

    // Monitor, all values seen as they were just before the edge
    always @(posedge clk) begin : monitor
        operand_t exp_op;
        int       nwr;
        logic     exp_rdy;
        if (rst) begin
            for (int s = 0; s < 3; s++) ptr[s] = base_of(s);
        end else begin
            // Each stream yields to any valid stream above it
            for (int s = 0; s < 3; s++) begin
                exp_rdy = 1'b1;
                for (int h = 0; h < s; h++) begin
                    if (rv[h]) exp_rdy = 1'b0;
                end
                assert (rr[s] === exp_rdy) else begin
                    errors++;
                    $display("[FAIL] t=%0t %s: got %b expected %b", $time, ready_name(s),
                             rr[s], exp_rdy);
                end
            end
            // Write-back needs an idle port and an outstanding instruction
            exp_rdy = !(rv[0] || rv[1] || rv[2]) && dq.size() != 0;
            assert (wb_ready === exp_rdy) else begin
                errors++;
                $display("[FAIL] t=%0t wb_ready: got %b expected %b", $time, wb_ready, exp_rdy);
            end
            // Pipe free to move and room left in the destination queue
            exp_rdy = (!op_valid || op_ready) && dq.size() < `DM_WB_QDEPTH;
            assert (inst_ready === exp_rdy) else begin
                errors++;
                $display("[FAIL] t=%0t inst_ready: got %b expected %b", $time,
                         inst_ready, exp_rdy);
            end
            if (inst_valid && inst_ready) exp_q.push_back(ref_operand(inst));  // Pre-write view
            if (op_valid && op_ready) begin
                checks++;
                assert (exp_q.size() > 0) else begin
                    errors++;
                    $display("%0t: operand delivered with nothing outstanding", $time);
                end
                if (exp_q.size() > 0) begin
                    exp_op = exp_q.pop_front();
                    assert (op === exp_op) else begin
                        errors++;
                        $display("[FAIL] t=%0t op: got %h expected %h", $time, op, exp_op);
                    end
                end
            end
            nwr = 0;
            for (int s = 0; s < 3; s++) begin  // Priority order
                if (rv[s] && rr[s]) begin
                    model[ptr[s]] = rb[s].data;
                    ptr[s] = rb[s].last ? base_of(s) : ptr[s] + addr_t'(1);
                    nwr++;
                end
            end
            if (wb_valid && wb_ready && dq.size() > 0) begin
                model[dq.pop_front()] = wb_data;  // Oldest instruction first
                nwr++;
            end
            assert (nwr <= 1) else begin
                errors++;
                $display("%0t: more than one write accepted in one cycle", $time);
            end
            if (inst_valid && inst_ready) dq.push_back(inst.dest);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        int e0, l1, l2, ls, lt;
        void'($urandom(66));
        rst = 1'b1;
        bp_on = 1'b0;
        inst_valid = 1'b0;
        inst = '0;
        for (int s = 0; s < 3; s++) begin
            rv[s] = 1'b0;
            rb[s] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        e0 = errors;
        checks += 2;
        assert (op_valid === 1'b0) else begin
            errors++;
            $display("[FAIL] t=%0t op_valid: got %b expected 0", $time, op_valid);
        end
        assert (wb_ready === 1'b0) else begin
            errors++;
            $display("[FAIL] t=%0t wb_ready: got %b expected 0", $time, wb_ready);
        end
        finish_test("idle after reset", e0);
        @(posedge clk);
        send_burst(0, `DM_DEPTH, 1'b1);  // Whole memory known before any read

        e0 = errors;
        l1 = 6 + $urandom % 12;
        l2 = 2 + $urandom % (l1 - 2);  // Shorter, so old words remain above
        send_burst(0, l1, 1'b0);
        send_burst(0, l2, 1'b0);
        read_span(`DM_LOAD_BASE, l1);
        finish_test("load burst restarts at base", e0);

        e0 = errors;
        ls = 4 + $urandom % 16;
        lt = 4 + $urandom % 16;
        send_burst(1, ls, 1'b0);
        send_burst(2, lt, 1'b0);
        read_span(`DM_SHIFT_BASE, ls);
        read_span(`DM_TX_BASE, lt);
        finish_test("shift and tx regions", e0);

        e0 = errors;
        fork
            send_burst(0, 6, 1'b0);
            send_burst(1, 7, 1'b0);
            send_burst(2, 8, 1'b0);
            begin
                for (int i = 0; i < 4; i++) send_inst(dm_inst_t'(24'($urandom)));
                inst_valid <= 1'b0;
            end
        join
        drain();
        read_span(`DM_LOAD_BASE, 6);
        read_span(`DM_SHIFT_BASE, 7);
        read_span(`DM_TX_BASE, 8);
        read_span(0, `DM_DEPTH);  // Catch stray writes anywhere
        finish_test("all writers at once", e0);

        e0 = errors;
        for (int i = 0; i < 6; i++) begin
            send_inst(dm_inst_t'{src_b: addr_t'($urandom), src_a: addr_t'($urandom),
                                 dest: addr_t'(224 + i)});
        end
        inst_valid <= 1'b0;
        drain();
        read_span(224, 6);
        finish_test("write-back order", e0);

        e0 = errors;
        bp_on <= 1'b1;
        // Sources stay below the write-back targets while reads stall
        for (int i = 0; i < 24; i++) begin
            send_inst(dm_inst_t'{src_b: addr_t'($urandom % 224), src_a: addr_t'($urandom % 224),
                                 dest: addr_t'(240 + $urandom % 16)});
        end
        inst_valid <= 1'b0;
        drain();
        bp_on <= 1'b0;
        finish_test("operand back-pressure", e0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
